// ==== compile.f ====
design/clk_rst_pkg.sv
design/cfg_router.sv
design/clk_div_channel.sv
design/rst_sequencer.sv
design/clk_rst_gen.sv
testbench/tb_clk_rst_gen.sv

// ==== Makefile ====
# Verilator flow for the clock and reset generator

TOP   := tb_clk_rst_gen
BUILD := obj_dir

.PHONY: all lint build sim clean

all: sim

# static checks over the whole source list
lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

build:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) \
		-Mdir $(BUILD) -o sim_$(TOP)

# the log decides the result, a missing pass line fails the target
sim: build
	-./$(BUILD)/sim_$(TOP) > sim.log 2>&1
	cat sim.log
	@grep -q "Simulation PASSED" sim.log || (echo "pass line not found in sim.log"; exit 1)

clean:
	rm -rf $(BUILD) sim.log

// ==== testbench/tb_clk_rst_gen.sv ====
// ------------------------------
// clock and reset generator tb
// ------------------------------

module tb_clk_rst_gen;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_CH          = clk_rst_pkg::NUM_CH;
  localparam int LOCK_PERIODS    = 4;  // dut defaults
  localparam int RST_DELAY       = 2;
  localparam int NUM_TXN         = 400;
  localparam int WATCHDOG_CYCLES = NUM_TXN * 40 + 1000;

  logic                  clk;
  logic                  rst_n_i;
  logic                  cfg_req_valid_i;
  logic                  cfg_req_ready_o;
  clk_rst_pkg::cfg_req_t cfg_req_i;
  logic                  cfg_rsp_valid_o;
  logic                  cfg_rsp_ready_i;
  clk_rst_pkg::cfg_rsp_t cfg_rsp_o;
  logic [NUM_CH-1:0]     clk_en_o;
  logic [NUM_CH-1:0]     rst_n_dom_o;
  logic                  all_locked_o;

  // reference model state, mirrors the dut registers of the current cycle
  logic [7:0]        m_ratio [NUM_CH];
  logic [7:0]        m_cnt   [NUM_CH];
  logic              m_en    [NUM_CH];
  logic              m_gate  [NUM_CH];
  int                m_per   [NUM_CH];
  int                m_stab  [NUM_CH];
  logic [NUM_CH-1:0] m_rst;
  logic              m_all;
  logic              m_rsp_valid;
  logic [31:0]       m_rsp_rdata;
  logic              m_rsp_err;
  int                accept_count  = 0;
  int                rsp_count     = 0;
  logic              reset_seen    = 1'b0;
  logic              soc_released  = 1'b0;

  clk_rst_gen dut_i (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .cfg_req_valid_i(cfg_req_valid_i),
    .cfg_req_ready_o(cfg_req_ready_o),
    .cfg_req_i      (cfg_req_i),
    .cfg_rsp_valid_o(cfg_rsp_valid_o),
    .cfg_rsp_ready_i(cfg_rsp_ready_i),
    .cfg_rsp_o      (cfg_rsp_o),
    .clk_en_o       (clk_en_o),
    .rst_n_dom_o    (rst_n_dom_o),
    .all_locked_o   (all_locked_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic report_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    $display("Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
    $display("Simulation FAILED");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic report_failure(input string what);
    $display("Error at %0t ns: %s", $time, what);
    $display("Simulation FAILED");
    $fatal(1, "stopped at the first failed check");
  endtask

  task automatic reset_model();
    for (int k = 0; k < NUM_CH; k++) begin
      m_ratio[k] = 8'd0;
      m_cnt[k]   = 8'd0;
      m_en[k]    = 1'b0;
      m_gate[k]  = 1'b0;
      m_per[k]   = 0;
      m_stab[k]  = 0;
    end
    m_rst       = '0;
    m_all       = 1'b0;
    m_rsp_valid = 1'b0;
  endtask

  task automatic check_outputs();
    logic exp_en;
    for (int k = 0; k < NUM_CH; k++) begin
      exp_en = m_en[k] && (m_cnt[k] == m_ratio[k]) && !m_gate[k];  // last count of a period
      assert (clk_en_o[k] === exp_en)
        else report_value($sformatf("clk_en_o[%0d]", k), 32'(exp_en), 32'(clk_en_o[k]));
    end
    assert (rst_n_dom_o === m_rst)
      else report_value("rst_n_dom_o", 32'(m_rst), 32'(rst_n_dom_o));
    assert (!(|rst_n_dom_o[NUM_CH-1:1]) || rst_n_dom_o[0])
      else report_failure("a domain left reset while the soc domain was still in reset");
    assert (all_locked_o === m_all)
      else report_value("all_locked_o", 32'(m_all), 32'(all_locked_o));
    assert (cfg_req_ready_o === (!m_rsp_valid || cfg_rsp_ready_i))
      else report_value("cfg_req_ready_o", 32'(!m_rsp_valid || cfg_rsp_ready_i),
                        32'(cfg_req_ready_o));
    assert (cfg_rsp_valid_o === m_rsp_valid)
      else report_value("cfg_rsp_valid_o", 32'(m_rsp_valid), 32'(cfg_rsp_valid_o));
    if (m_rsp_valid) begin  // payload must also hold while stalled
      assert (cfg_rsp_o.rdata === m_rsp_rdata)
        else report_value("cfg_rsp_o.rdata", m_rsp_rdata, cfg_rsp_o.rdata);
      assert (cfg_rsp_o.err === m_rsp_err)
        else report_value("cfg_rsp_o.err", 32'(m_rsp_err), 32'(cfg_rsp_o.err));
    end
    // responses the dut hands over on the coming edge
    if (cfg_rsp_valid_o === 1'b1 && cfg_rsp_ready_i === 1'b1) begin
      rsp_count++;
    end
    if (rst_n_dom_o[0]) begin
      soc_released = 1'b1;
    end
  endtask

  task automatic advance_model();
    logic              accept;
    logic              legal;
    logic              wrap;
    logic              wr;
    logic              soc_out;
    logic [1:0]        addr;
    logic [31:0]       word;
    logic [31:0]       rd;
    logic [NUM_CH-1:0] lock_now;
    logic [NUM_CH-1:0] stable;
    int                ch;
    ch     = int'(cfg_req_i.ch);
    addr   = cfg_req_i.addr;
    word   = cfg_req_i.wdata;
    accept = cfg_req_valid_i && (!m_rsp_valid || cfg_rsp_ready_i);
    legal  = (ch < NUM_CH) && (addr != 2'd3) && !(cfg_req_i.write && addr == 2'd2);
    if (accept) begin
      rd = 32'd0;
      if (legal && !cfg_req_i.write) begin
        case (addr)
          2'd0:    rd = {24'd0, m_ratio[ch]};
          2'd1:    rd = {30'd0, m_gate[ch], m_en[ch]};
          default: rd = {22'd0, m_per[ch] == LOCK_PERIODS, m_en[ch], m_ratio[ch]};
        endcase
      end
      m_rsp_valid = 1'b1;
      m_rsp_rdata = rd;
      m_rsp_err   = !legal;
      accept_count++;
    end else if (cfg_rsp_ready_i) begin
      m_rsp_valid = 1'b0;
    end
    for (int k = 0; k < NUM_CH; k++) begin
      lock_now[k] = (m_per[k] == LOCK_PERIODS);
      wrap        = m_en[k] && (m_cnt[k] == m_ratio[k]);
      wr          = accept && legal && cfg_req_i.write && (ch == k);
      // counters step on the old enable, the write lands on the same edge
      if (wr || !m_en[k]) begin
        m_cnt[k] = 8'd0;
        m_per[k] = 0;
      end else if (wrap) begin
        m_cnt[k] = 8'd0;
        if (!lock_now[k]) m_per[k]++;
      end else begin
        m_cnt[k] = m_cnt[k] + 8'd1;
      end
      if (wr && addr == 2'd0) m_ratio[k] = word[7:0];
      if (wr && addr == 2'd1) begin
        m_en[k]   = word[0];
        m_gate[k] = word[1];
      end
      if (!lock_now[k]) m_stab[k] = 0;
      else if (m_stab[k] < RST_DELAY) m_stab[k]++;
      stable[k] = lock_now[k] && (m_stab[k] == RST_DELAY);
    end
    // soc first, the others need soc already out of reset and still stable
    soc_out  = m_rst[0];  // soc reset as it stood before this edge
    m_rst[0] = stable[0];
    for (int k = 1; k < NUM_CH; k++) begin
      m_rst[k] = stable[k] && soc_out && stable[0];
    end
    m_all = &lock_now;
  endtask

  // checks and model run mid-cycle where inputs and outputs are settled
  always @(negedge clk) begin
    if (!rst_n_i) begin
      if (reset_seen) check_outputs();
      reset_model();
      reset_seen = 1'b1;
    end else begin
      check_outputs();
      advance_model();
    end
  end

  function automatic clk_rst_pkg::cfg_req_t random_request();
    clk_rst_pkg::cfg_req_t req;
    logic [31:0]           word;
    req.ch    = 2'($urandom % 4);  // 3 is an illegal target
    req.write = 1'($urandom % 2);
    req.addr  = clk_rst_pkg::cfg_addr_e'(2'($urandom % 4));
    word      = $urandom;
    if (req.addr == clk_rst_pkg::REG_DIV) begin
      // mostly short periods so lock is reached between writes
      word[7:0] = (($urandom % 4) == 0) ? 8'($urandom) : 8'($urandom % 8);
    end else if (req.addr == clk_rst_pkg::REG_CTRL) begin
      word[0] = ($urandom % 4) != 0;
    end
    req.wdata = word;
    return req;
  endfunction

  function automatic int pick_gap();
    if (($urandom % 8) == 0) return 20 + int'($urandom % 60);  // long idle lets domains lock
    return int'($urandom % 3);
  endfunction

  task automatic run_traffic();
    int issued;
    int gap;
    issued = 0;
    gap    = 0;
    while (accept_count < NUM_TXN) begin
      @(posedge clk);
      #1;
      cfg_rsp_ready_i = ($urandom % 4) != 0;
      if (cfg_req_valid_i && accept_count == issued) begin
        cfg_req_valid_i = 1'b0;  // taken on the last edge
        gap = pick_gap();
      end
      if (!cfg_req_valid_i && issued < NUM_TXN) begin
        if (gap == 0) begin
          cfg_req_i       = random_request();
          cfg_req_valid_i = 1'b1;
          issued++;
        end else begin
          gap--;
        end
      end
    end
  endtask

  initial begin
    void'($urandom(32'hbf90));
    rst_n_i         = 1'b0;
    cfg_req_valid_i = 1'b0;
    cfg_req_i       = '0;
    cfg_rsp_ready_i = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_n_i = 1'b1;
    run_traffic();
    while (rsp_count < NUM_TXN) begin
      @(posedge clk);
      #1;
      cfg_rsp_ready_i = ($urandom % 4) != 0;
    end
    cfg_rsp_ready_i = 1'b1;
    repeat (300) @(posedge clk);  // let the last settings lock and release
    #1;
    assert (rsp_count == accept_count)
      else report_failure("the number of responses does not match the accepted requests");
    assert (soc_released)
      else report_failure("the soc domain never left reset during the run");
    $display("Simulation PASSED");
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * 10);
    $display("Watchdog expired, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation FAILED");
    $fatal(1, "watchdog timeout");
  end

endmodule

// ==== design/clk_rst_gen.sv ====
// ------------------------------
// clock and reset generator top
// ------------------------------

module clk_rst_gen #(
  parameter int NUM_CH       = clk_rst_pkg::NUM_CH,
  parameter int LOCK_PERIODS = 4,
  parameter int RST_DELAY    = 2
) (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   cfg_req_valid_i,
  output logic                   cfg_req_ready_o,
  input  clk_rst_pkg::cfg_req_t  cfg_req_i,
  output logic                   cfg_rsp_valid_o,
  input  logic                   cfg_rsp_ready_i,
  output clk_rst_pkg::cfg_rsp_t  cfg_rsp_o,
  output logic [NUM_CH-1:0]      clk_en_o,
  output logic [NUM_CH-1:0]      rst_n_dom_o,
  output logic                   all_locked_o
);

  clk_rst_pkg::ch_cmd_t  [NUM_CH-1:0] ch_cmd;
  clk_rst_pkg::ch_stat_t [NUM_CH-1:0] ch_stat;
  logic                  [NUM_CH-1:0] ch_lock;

  // single config port shared by all domains
  cfg_router #(
    .NUM_CH(NUM_CH)
  ) cfg_router_i (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .req_valid_i(cfg_req_valid_i),
    .req_ready_o(cfg_req_ready_o),
    .req_i      (cfg_req_i),
    .rsp_valid_o(cfg_rsp_valid_o),
    .rsp_ready_i(cfg_rsp_ready_i),
    .rsp_o      (cfg_rsp_o),
    .ch_cmd_o   (ch_cmd),
    .ch_stat_i  (ch_stat)
  );

  // channel 0 is soc, 1 peripheral, 2 cluster
  for (genvar k = 0; k < NUM_CH; k++) begin : g_ch
    clk_div_channel #(
      .LOCK_PERIODS(LOCK_PERIODS)
    ) clk_div_channel_i (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .cmd_i   (ch_cmd[k]),
      .stat_o  (ch_stat[k]),
      .clk_en_o(clk_en_o[k]),
      .lock_o  (ch_lock[k])
    );
  end

  rst_sequencer #(
    .NUM_CH   (NUM_CH),
    .RST_DELAY(RST_DELAY)
  ) rst_sequencer_i (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .lock_i      (ch_lock),
    .rst_n_dom_o (rst_n_dom_o),
    .all_locked_o(all_locked_o)
  );

endmodule

// ==== design/rst_sequencer.sv ====
// ------------------------------
// domain reset sequencer
// ------------------------------

module rst_sequencer #(
  parameter int NUM_CH    = clk_rst_pkg::NUM_CH,
  parameter int RST_DELAY = 2
) (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic [NUM_CH-1:0] lock_i,
  output logic [NUM_CH-1:0] rst_n_dom_o,
  output logic              all_locked_o
);

  // a zero delay still needs one counter bit
  localparam int STAB_W = (RST_DELAY > 0) ? $clog2(RST_DELAY + 1) : 1;

  logic [STAB_W-1:0] stab_q [NUM_CH];
  logic [STAB_W-1:0] stab_d [NUM_CH];
  logic [NUM_CH-1:0] stable;
  logic [NUM_CH-1:0] rst_n_d;
  logic [NUM_CH-1:0] rst_n_q;
  logic              all_locked_q;

  always_comb begin
    for (int k = 0; k < NUM_CH; k++) begin
      // counts cycles of unbroken lock, any drop starts over
      if (!lock_i[k]) begin
        stab_d[k] = '0;
      end else if (stab_q[k] == STAB_W'(RST_DELAY)) begin
        stab_d[k] = stab_q[k];
      end else begin
        stab_d[k] = stab_q[k] + 1'b1;
      end
      stable[k] = lock_i[k] && (stab_d[k] == STAB_W'(RST_DELAY));
    end

    // soc goes first, the others wait until it is out of reset
    // and all of them follow it back into reset on the same edge
    rst_n_d[0] = stable[0];
    for (int k = 1; k < NUM_CH; k++) begin
      rst_n_d[k] = stable[k] && rst_n_q[0] && rst_n_d[0];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int k = 0; k < NUM_CH; k++) begin
        stab_q[k] <= '0;
      end
      rst_n_q      <= '0;
      all_locked_q <= 1'b0;
    end else begin
      for (int k = 0; k < NUM_CH; k++) begin
        stab_q[k] <= stab_d[k];
      end
      rst_n_q      <= rst_n_d;
      all_locked_q <= &lock_i;
    end
  end

  assign rst_n_dom_o  = rst_n_q;
  assign all_locked_o = all_locked_q;

endmodule

// ==== design/clk_div_channel.sv ====
// ------------------------------
// domain clock divider channel
// ------------------------------

module clk_div_channel #(
  parameter int LOCK_PERIODS = 4
) (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  clk_rst_pkg::ch_cmd_t   cmd_i,
  output clk_rst_pkg::ch_stat_t  stat_o,
  output logic                   clk_en_o,
  output logic                   lock_o
);

  localparam int PER_W = $clog2(LOCK_PERIODS + 1);

  logic [clk_rst_pkg::RATIO_W-1:0] ratio_q;
  logic                            enable_q;
  logic                            gate_q;
  logic [clk_rst_pkg::RATIO_W-1:0] cnt_q;
  logic [PER_W-1:0]                per_cnt_q;
  logic                            cfg_wr;
  logic                            wrap;
  logic                            locked;
  clk_rst_pkg::cfg_word_u          rd_word;

  // the router has already filtered out illegal writes
  assign cfg_wr = cmd_i.valid && cmd_i.write;
  assign wrap   = enable_q && (cnt_q == ratio_q);  // last cycle of a period
  assign locked = per_cnt_q == PER_W'(LOCK_PERIODS);

  // register file, only the decoded fields are kept
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ratio_q  <= '0;
      enable_q <= 1'b0;
      gate_q   <= 1'b0;
    end else if (cfg_wr) begin
      case (cmd_i.addr)
        clk_rst_pkg::REG_DIV: begin
          ratio_q <= cmd_i.wdata.div_view.ratio;
        end
        clk_rst_pkg::REG_CTRL: begin
          enable_q <= cmd_i.wdata.ctrl_view.enable;
          gate_q   <= cmd_i.wdata.ctrl_view.gate;
        end
        default: ;
      endcase
    end
  end

  // ratio counter and lock period counter
  // any configuration write restarts both, which also covers enable toggles
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      cnt_q     <= '0;
      per_cnt_q <= '0;
    end else if (cfg_wr || !enable_q) begin
      cnt_q     <= '0;
      per_cnt_q <= '0;
    end else if (wrap) begin
      cnt_q <= '0;
      if (!locked) begin
        per_cnt_q <= per_cnt_q + 1'b1;  // saturates at LOCK_PERIODS
      end
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // gating only hides the pulse, the counter keeps running
  assign clk_en_o = wrap && !gate_q;
  assign lock_o   = locked;

  // readback word selected by the command address
  always_comb begin
    rd_word = '0;
    case (cmd_i.addr)
      clk_rst_pkg::REG_DIV: begin
        rd_word.div_view.ratio = ratio_q;
      end
      clk_rst_pkg::REG_CTRL: begin
        rd_word.ctrl_view.enable = enable_q;
        rd_word.ctrl_view.gate   = gate_q;
      end
      clk_rst_pkg::REG_STATUS: begin
        rd_word.div_view.ratio                 = ratio_q;
        rd_word[clk_rst_pkg::STAT_EN_BIT]   = enable_q;
        rd_word[clk_rst_pkg::STAT_LOCK_BIT] = locked;
      end
      default: ;
    endcase
  end

  assign stat_o.rdata   = rd_word;
  assign stat_o.lock    = locked;
  assign stat_o.running = enable_q;

endmodule

// ==== design/cfg_router.sv ====
// ------------------------------
// configuration router
// ------------------------------

module cfg_router #(
  parameter int NUM_CH = clk_rst_pkg::NUM_CH
) (
  input  logic                                clk,
  input  logic                                rst_n_i,
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  input  clk_rst_pkg::cfg_req_t               req_i,
  output logic                                rsp_valid_o,
  input  logic                                rsp_ready_i,
  output clk_rst_pkg::cfg_rsp_t               rsp_o,
  output clk_rst_pkg::ch_cmd_t [NUM_CH-1:0]  ch_cmd_o,
  input  clk_rst_pkg::ch_stat_t [NUM_CH-1:0] ch_stat_i
);

  logic                  rsp_valid_q;
  clk_rst_pkg::cfg_rsp_t rsp_q;
  logic                  accept;
  logic                  ch_ok;
  logic                  addr_ok;
  logic                  legal;
  logic [31:0]           sel_rdata;

  // one response slot, a new request may enter as the old response leaves
  assign req_ready_o = !rsp_valid_q || rsp_ready_i;
  assign accept      = req_valid_i && req_ready_o;

  assign ch_ok   = int'(req_i.ch) < NUM_CH;
  assign addr_ok = (req_i.addr != 2'd3) &&
                   !(req_i.write && (req_i.addr == clk_rst_pkg::REG_STATUS));
  assign legal   = ch_ok && addr_ok;

  always_comb begin
    sel_rdata = '0;
    for (int k = 0; k < NUM_CH; k++) begin
      // address and data fan out to every channel, only the target sees valid
      ch_cmd_o[k].valid = accept && legal && (req_i.ch == clk_rst_pkg::CH_IDX_W'(k));
      ch_cmd_o[k].write = req_i.write;
      ch_cmd_o[k].addr  = req_i.addr;
      ch_cmd_o[k].wdata = req_i.wdata;
      if (req_i.ch == clk_rst_pkg::CH_IDX_W'(k)) begin
        sel_rdata = ch_stat_i[k].rdata;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // the payload only moves on acceptance, so it holds under back-pressure
  always_ff @(posedge clk) begin
    if (accept) begin
      rsp_q.err   <= !legal;
      rsp_q.rdata <= (legal && !req_i.write) ? sel_rdata : 32'd0;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

// ==== design/clk_rst_pkg.sv ====
// ------------------------------
// clock and reset shared types
// ------------------------------

package clk_rst_pkg;

  // number of generated domains: soc, peripheral, cluster
  parameter int NUM_CH   = 3;
  parameter int CH_IDX_W = 2;  // index 3 has no channel behind it
  parameter int RATIO_W  = 8;

  // register map of one channel, code 3 is not decoded
  typedef enum logic [1:0] {
    REG_DIV    = 2'd0,
    REG_CTRL   = 2'd1,
    REG_STATUS = 2'd2  // read only
  } cfg_addr_e;

  // divider word, output period is ratio + 1 cycles
  typedef struct packed {
    logic [23:0]        rsvd;
    logic [RATIO_W-1:0] ratio;
  } div_word_t;

  // control word
  typedef struct packed {
    logic [29:0] rsvd;
    logic        gate;    // keeps counting but holds the enable output low
    logic        enable;  // runs the divider
  } ctrl_word_t;

  // the same 32 bits seen as either register, picked by the address
  typedef union packed {
    div_word_t  div_view;
    ctrl_word_t ctrl_view;
  } cfg_word_u;

  // request on the shared configuration port
  typedef struct packed {
    logic [CH_IDX_W-1:0] ch;
    logic                write;
    cfg_addr_e           addr;
    cfg_word_u           wdata;
  } cfg_req_t;

  // response, rdata is zero for writes and errors
  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } cfg_rsp_t;

  // strobe from the router into one channel
  typedef struct packed {
    logic      valid;  // high in the accept cycle only
    logic      write;
    cfg_addr_e addr;
    cfg_word_u wdata;
  } ch_cmd_t;

  // readback from a channel, rdata follows the command address
  typedef struct packed {
    logic [31:0] rdata;
    logic        lock;
    logic        running;
  } ch_stat_t;

  // bit positions of the status word
  parameter int STAT_EN_BIT   = 8;
  parameter int STAT_LOCK_BIT = 9;

endpackage
